//--- cpu_core.f
+incdir+include
rtl/cpu_core_pkg.sv
rtl/cpu_fetch.sv
rtl/cpu_decode.sv
rtl/cpu_hazard.sv
rtl/cpu_execute.sv
rtl/cpu_memory.sv
rtl/cpu_core.sv
bench/cpu_core_tb.sv

//--- Bender.yml
package:
  name: cpu_core

sources:
  - include_dirs:
      - include
    files:
      - rtl/cpu_core_pkg.sv
      - rtl/cpu_fetch.sv
      - rtl/cpu_decode.sv
      - rtl/cpu_hazard.sv
      - rtl/cpu_execute.sv
      - rtl/cpu_memory.sv
      - rtl/cpu_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/cpu_core_tb.sv

//--- bench/cpu_core_tb.sv
`timescale 1ns/1ns
`include "cpu_core_cfg.svh"
////////////////////
// cpu core testbench
// directed programs checked against an instruction set model
////////////////////
module cpu_core_tb import cpu_core_pkg::*; ();

    logic      clk;
    logic      rst_n;
    load_t     load;
    logic      start;
    logic      host_ack;
    logic      running;
    logic      host_wr;
    host_req_t host_req;

    word_t       prog [$];
    addr_t       exp_addr [$];
    word_t       exp_data [$];
    logic [31:0] lcg_state;

    cpu_core UUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .load     (load),
        .start    (start),
        .host_ack (host_ack),
        .running  (running),
        .host_wr  (host_wr),
        .host_req (host_req)
    );

    always #4 clk = ~clk;   // 8 ns period

    //////////////////// checking

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("Fail %s: got %h, expected %h", name, got, exp));
        end
    endtask

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {8'h00, lcg_state[31:8]};   // low bits of an lcg repeat quickly
    endfunction

    //////////////////// program builder

    function automatic word_t rtype(opcode_t op, reg_idx_t rd, reg_idx_t rs, reg_idx_t rt);
        return {op, rd, rs, rt, 12'h000};
    endfunction

    function automatic word_t itype(opcode_t op, reg_idx_t rd, reg_idx_t rs, logic [15:0] imm);
        return {op, rd, rs, imm};
    endfunction

    task automatic emit(input word_t w);
        prog.push_back(w);
    endtask

    task automatic halt();
        emit(itype(OP_JMP, 0, 0, 16'(prog.size() * 4)));   // jump to itself
    endtask

    //////////////////// reference model

    function automatic word_t alu_ref(opcode_t op, word_t a, word_t b);
        case (op)
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            default: return a + b;
        endcase
    endfunction

    // runs prog until the self jump and lists the host writes in order
    task automatic run_model();
        word_t    r [`CPU_NREG];
        word_t    dm [`CPU_DMEM_WORDS];
        logic     zf, nf, taken, halted;
        int       pc, pc_next, steps;
        word_t    ins, imm, res;
        addr_t    ea;
        opcode_t  op;
        reg_idx_t rd, rs, rt;
        exp_addr.delete();
        exp_data.delete();
        foreach (r[i]) r[i] = '0;
        foreach (dm[i]) dm[i] = '0;
        zf = 1'b0;
        nf = 1'b0;
        halted = 1'b0;
        pc = 0;
        steps = 0;
        while (!halted) begin
            if (steps > 2000) begin
                report_failure("reference model never reached the halt loop");
            end
            ins = (pc / 4 < prog.size()) ? prog[pc / 4] : '0;
            op = opcode_t'(ins[31:24]);
            rd = ins[23:20];
            rs = ins[19:16];
            rt = ins[15:12];
            imm = {{16{ins[15]}}, ins[15:0]};
            pc_next = pc + 4;
            taken = 1'b0;
            res = r[rs] + imm;
            ea = res[15:0];
            case (op)
                OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI: begin
                    res = alu_ref(op, r[rs], (op == OP_ADDI) ? imm : r[rt]);
                    r[rd] = res;
                    zf = (res == '0);
                    nf = res[31];
                end
                OP_LD: r[rd] = dm[ea[9:2]];   // 256 word memory
                OP_ST: begin
                    if (ea >= `CPU_HOST_BASE) begin
                        exp_addr.push_back(ea);
                        exp_data.push_back(r[rd]);
                    end else begin
                        dm[ea[9:2]] = r[rd];
                    end
                end
                OP_BEQ: taken = zf;
                OP_BNE: taken = !zf;
                OP_BLT: taken = nf;
                OP_JMP: taken = 1'b1;
                default: taken = 1'b0;
            endcase
            if (taken && ins[15:0] == 16'(pc)) begin
                halted = 1'b1;
            end else if (taken) begin
                pc_next = ins[15:0];
            end
            pc = pc_next;
            steps++;
        end
    endtask

    //////////////////// DUT control

    task automatic reset_dut();
        rst_n = 1'b0;
        load = '0;
        start = 1'b0;
        host_ack = 1'b0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("running", running, 0);
        check_value("host_wr", host_wr, 0);
    endtask

    task automatic load_program();
        foreach (prog[i]) begin
            load.en = 1'b1;
            load.addr = addr_t'(i * 4);
            load.data = prog[i];
            @(negedge clk);
            check_value("running", running, 0);
            check_value("host_wr", host_wr, 0);
        end
        load = '0;
    endtask

    task automatic start_cpu();
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        check_value("running", running, 1);
    endtask

    // host side of one write, ack after a random number of cycles
    task automatic serve_write(input addr_t ea, input word_t ed, input int min_d, input int span);
        int        cnt;
        int        delay;
        host_req_t held;
        cnt = 0;
        while (host_wr !== 1'b1) begin
            if (cnt == 500) begin
                report_failure($sformatf("timed out waiting for the host write to %h", ea));
            end
            @(negedge clk);
            cnt++;
        end
        held = host_req;
        check_value("host_req.addr", host_req.addr, ea);
        check_value("host_req.data", host_req.data, ed);
        delay = min_d + int'(next_random() % span);
        repeat (delay) begin
            @(negedge clk);
            check_value("host_wr", host_wr, 1);
            check_value("host_req", host_req, held);
        end
        host_ack = 1'b1;
        @(negedge clk);
        host_ack = 1'b0;
    endtask

    task automatic run_program(input string name, input int min_d, input int span);
        run_model();
        reset_dut();
        load_program();
        start_cpu();
        foreach (exp_addr[i]) begin
            serve_write(exp_addr[i], exp_data[i], min_d, span);
        end
        repeat (40) begin   // core sits in its halt loop now
            @(negedge clk);
            check_value("host_wr", host_wr, 0);
            check_value("running", running, 1);
        end
        $display("%s: %0d host writes checked", name, exp_addr.size());
    endtask

    //////////////////// tests

    task automatic alu_ops();
        prog.delete();
        emit(itype(OP_ADDI, 1, 0, 16'h1234));
        emit(itype(OP_ADDI, 2, 0, 16'hF0F1));   // negative operand
        emit(rtype(OP_ADD, 3, 1, 2));
        emit(rtype(OP_SUB, 4, 1, 2));
        emit(rtype(OP_AND, 5, 1, 2));
        emit(rtype(OP_OR, 6, 1, 2));
        emit(rtype(OP_XOR, 7, 1, 2));
        emit(rtype(OP_SUB, 8, 2, 1));
        for (int i = 3; i <= 8; i++) begin
            emit(itype(OP_ST, reg_idx_t'(i), 0, 16'(16'h9000 + (i - 3) * 4)));
        end
        emit(itype(OP_ST, 2, 0, 16'hFFFC));   // top of the host window
        halt();
        run_program("alu", 0, 3);
    endtask

    task automatic raw_chain();
        prog.delete();
        emit(itype(OP_ADDI, 1, 0, 16'd3));
        emit(rtype(OP_ADD, 2, 1, 1));
        emit(rtype(OP_ADD, 3, 2, 1));
        emit(rtype(OP_SUB, 4, 3, 2));
        emit(rtype(OP_XOR, 5, 4, 3));
        emit(itype(OP_ADDI, 5, 5, 16'd7));
        emit(itype(OP_ST, 5, 0, 16'h9020));
        emit(itype(OP_ADDI, 6, 5, 16'hFFEC));
        emit(itype(OP_ST, 6, 0, 16'h9024));    // store data right behind its writer
        emit(itype(OP_ADDI, 7, 0, 16'h0010));
        emit(itype(OP_ST, 4, 7, 16'h9030));    // base register just written
        halt();
        run_program("raw chain", 0, 4);
    endtask

    task automatic data_memory();
        prog.delete();
        emit(itype(OP_ADDI, 1, 0, 16'h05A5));
        emit(itype(OP_ADDI, 2, 0, 16'h0040));
        emit(itype(OP_ST, 1, 2, 16'h0000));
        emit(itype(OP_ADDI, 3, 1, 16'h0100));
        emit(itype(OP_ST, 3, 2, 16'h0004));
        emit(itype(OP_ST, 3, 0, 16'h8FFC));    // last local word
        emit(itype(OP_LD, 4, 2, 16'h0000));
        emit(itype(OP_LD, 5, 2, 16'h0004));
        emit(itype(OP_LD, 6, 0, 16'h8FFC));
        emit(rtype(OP_ADD, 7, 4, 5));
        emit(itype(OP_ST, 4, 0, 16'h9100));
        emit(itype(OP_ST, 7, 0, 16'h9104));
        emit(itype(OP_ST, 6, 0, 16'h9108));
        halt();
        run_program("data memory", 1, 3);
    endtask

    task automatic branches();
        prog.delete();
        emit(itype(OP_ADDI, 1, 0, 16'd5));     // 0
        emit(itype(OP_ADDI, 2, 0, 16'd5));     // 4
        emit(rtype(OP_SUB, 3, 1, 2));          // 8  zf set
        emit(itype(OP_BEQ, 0, 0, 16'd20));     // 12 taken
        emit(itype(OP_ST, 1, 0, 16'h9200));    // 16 skipped
        emit(itype(OP_ST, 3, 0, 16'h9204));    // 20
        emit(itype(OP_BNE, 0, 0, 16'd36));     // 24 not taken
        emit(itype(OP_ST, 1, 0, 16'h9208));    // 28
        emit(itype(OP_ADDI, 4, 0, 16'hFFFF));  // 32 nf set
        emit(itype(OP_BLT, 0, 0, 16'd44));     // 36 taken
        emit(itype(OP_ST, 4, 0, 16'h920C));    // 40 skipped
        emit(itype(OP_BEQ, 0, 0, 16'd52));     // 44 not taken
        emit(itype(OP_ST, 2, 0, 16'h9210));    // 48
        emit(itype(OP_BNE, 0, 0, 16'd60));     // 52 taken
        emit(itype(OP_ST, 2, 0, 16'h9214));    // 56 skipped
        emit(itype(OP_ADDI, 5, 0, 16'd1));     // 60 nf clear
        emit(itype(OP_BLT, 0, 0, 16'd72));     // 64 not taken
        emit(itype(OP_ST, 5, 0, 16'h9218));    // 68
        emit(itype(OP_JMP, 0, 0, 16'd80));     // 72
        emit(itype(OP_ST, 5, 0, 16'h921C));    // 76 skipped
        emit(itype(OP_ST, 4, 0, 16'h9220));    // 80
        halt();
        run_program("branches", 0, 3);
    endtask

    task automatic back_pressure();
        prog.delete();
        emit(itype(OP_ADDI, 1, 0, 16'd3));
        emit(itype(OP_ADDI, 2, 0, 16'h0100));
        emit(itype(OP_ST, 1, 0, 16'h9300));    // 8  loop head
        emit(itype(OP_ST, 2, 0, 16'h9304));    // back to back host stores
        emit(rtype(OP_ADD, 2, 2, 1));
        emit(itype(OP_ADDI, 1, 1, 16'hFFFF));
        emit(itype(OP_BNE, 0, 0, 16'd8));
        emit(itype(OP_ST, 2, 0, 16'h9308));
        halt();
        run_program("back pressure", 4, 20);
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        load = '0;
        start = 1'b0;
        host_ack = 1'b0;
        lcg_state = 32'h6b026afb;
        alu_ops();
        raw_chain();
        data_memory();
        branches();
        back_pressure();
        $display("Done: no errors");
        $finish;
    end

endmodule

//--- rtl/cpu_core.sv
`timescale 1ns/1ns
////////////////////
// cpu core top level
// five stage pipeline with a host write port
////////////////////
module cpu_core import cpu_core_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  load_t     load,
    input  logic      start,
    input  logic      host_ack,
    output logic      running,
    output logic      host_wr,
    output host_req_t host_req
);

    word_t     instr;
    idex_t     idex;
    exmem_t    exmem;
    memwb_t    wb;
    redirect_t redirect;
    logic      rw_stall;
    logic      jb_stall;
    logic      freeze;       // host write pending

    cpu_fetch u_fetch (
        .clk      (clk),
        .rst_n    (rst_n),
        .load     (load),
        .start    (start),
        .redirect (redirect),
        .rw_stall (rw_stall),
        .jb_stall (jb_stall),
        .freeze   (freeze),
        .running  (running),
        .instr    (instr)
    );

    cpu_decode u_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .instr    (instr),
        .rw_stall (rw_stall),
        .freeze   (freeze),
        .wb       (wb),
        .idex     (idex)
    );

    cpu_hazard u_hazard (
        .instr    (instr),
        .idex     (idex),
        .exmem    (exmem),
        .rw_stall (rw_stall),
        .jb_stall (jb_stall)
    );

    cpu_execute u_execute (
        .clk      (clk),
        .rst_n    (rst_n),
        .idex     (idex),
        .freeze   (freeze),
        .redirect (redirect),
        .exmem    (exmem)
    );

    cpu_memory u_memory (
        .clk      (clk),
        .rst_n    (rst_n),
        .exmem    (exmem),
        .host_ack (host_ack),
        .freeze   (freeze),
        .host_wr  (host_wr),
        .host_req (host_req),
        .wb       (wb)
    );

endmodule

//--- rtl/cpu_memory.sv
`timescale 1ns/1ns
`include "cpu_core_cfg.svh"
////////////////////
// memory stage
// data memory, host write port and mem/wb register
////////////////////
module cpu_memory import cpu_core_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  exmem_t    exmem,
    input  logic      host_ack,
    output logic      freeze,
    output logic      host_wr,
    output host_req_t host_req,
    output memwb_t    wb
);

    localparam int DW = $clog2(`CPU_DMEM_WORDS);

    word_t dmem [`CPU_DMEM_WORDS];
    addr_t addr;
    logic  to_host;
    word_t ld_data;

    assign addr    = exmem.result[`CPU_AW-1:0];
    assign to_host = (addr >= `CPU_HOST_BASE);
    assign ld_data = dmem[addr[DW+1:2]];   // combinational load

    //////////////////// host path

    assign host_wr       = exmem.ctrl.mem_write && to_host;
    assign host_req.addr = addr;
    assign host_req.data = exmem.st_data;
    assign freeze        = host_wr && !host_ack;   // whole pipe waits on the ack

    // host stores never touch local memory
    always_ff @(posedge clk) begin
        if (exmem.ctrl.mem_write && !to_host) begin
            dmem[addr[DW+1:2]] <= exmem.st_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb <= '0;
        end else if (!freeze) begin
            wb.we     <= exmem.ctrl.reg_write;
            wb.rd     <= exmem.rd;
            wb.result <= exmem.ctrl.mem_read ? ld_data : exmem.result;
        end
    end

    a_host_req_stable : assert property (@(posedge clk) disable iff (!rst_n)
        host_wr && !host_ack |=> host_wr && $stable(host_req));

endmodule

//--- rtl/cpu_execute.sv
`timescale 1ns/1ns
`include "cpu_core_cfg.svh"
////////////////////
// execute stage
// alu, zf/nf flags, branch resolution and ex/mem register
////////////////////
module cpu_execute import cpu_core_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  idex_t     idex,
    input  logic      freeze,
    output redirect_t redirect,
    output exmem_t    exmem
);

    word_t a, b;
    word_t result;
    logic  zf, nf;
    logic  taken;

    assign a = idex.rs_val;
    assign b = idex.ctrl.imm_sel ? idex.imm : idex.rt_val;

    always_comb begin
        case (idex.ctrl.alu_op)
            OP_ADD, OP_ADDI, OP_LD, OP_ST: result = a + b;   // loads and stores add the offset
            OP_SUB:  result = a - b;
            OP_AND:  result = a & b;
            OP_OR:   result = a | b;
            OP_XOR:  result = a ^ b;
            default: result = '0;
        endcase
    end

    //////////////////// flags

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            zf <= 1'b0;
            nf <= 1'b0;
        end else if (!freeze && idex.ctrl.flag_set) begin
            zf <= (result == '0);
            nf <= result[`CPU_XLEN-1];
        end
    end

    // branches see the flags of the last alu op
    always_comb begin
        case (idex.ctrl.alu_op)
            OP_BEQ:  taken = zf;
            OP_BNE:  taken = !zf;
            OP_BLT:  taken = nf;
            OP_JMP:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign redirect.valid  = idex.ctrl.branch && taken;
    assign redirect.target = idex.imm[`CPU_AW-1:0];   // immediate is the byte target

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exmem <= '0;
        end else if (!freeze) begin
            exmem.ctrl    <= idex.ctrl;
            exmem.result  <= result;
            exmem.st_data <= idex.rt_val;
            exmem.rd      <= idex.rd;
        end
    end

    // a redirect comes only from a pure branch control
    a_redirect_branch : assert property (@(posedge clk) disable iff (!rst_n)
        redirect.valid |-> !idex.ctrl.reg_write && !idex.ctrl.mem_write
                           && !idex.ctrl.flag_set);

endmodule

//--- rtl/cpu_hazard.sv
`timescale 1ns/1ns
////////////////////
// hazard detection
// raw and branch-in-flight stalls
////////////////////
module cpu_hazard import cpu_core_pkg::*; (
    input  word_t  instr,
    input  idex_t  idex,
    input  exmem_t exmem,
    output logic   rw_stall,
    output logic   jb_stall
);

    opcode_t  op;
    reg_idx_t rd, rs, rt;
    logic     use_rs, use_rt, use_rd;
    logic     is_jb;
    logic     hit_ex, hit_mem;

    assign op = opcode_t'(instr[31:24]);
    assign rd = instr[23:20];
    assign rs = instr[19:16];
    assign rt = instr[15:12];

    // which fields the decode instruction reads
    always_comb begin
        use_rs = 1'b0;
        use_rt = 1'b0;
        use_rd = 1'b0;
        is_jb  = 1'b0;
        case (op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
                use_rs = 1'b1;
                use_rt = 1'b1;
            end
            OP_ADDI, OP_LD: use_rs = 1'b1;
            OP_ST: begin
                use_rs = 1'b1;
                use_rd = 1'b1;   // store source
            end
            OP_BEQ, OP_BNE, OP_BLT, OP_JMP: is_jb = 1'b1;
            default: is_jb = 1'b0;
        endcase
    end

    assign hit_ex  = idex.ctrl.reg_write && ((use_rs && rs == idex.rd) ||
                     (use_rt && rt == idex.rd) || (use_rd && rd == idex.rd));
    assign hit_mem = exmem.ctrl.reg_write && ((use_rs && rs == exmem.rd) ||
                     (use_rt && rt == exmem.rd) || (use_rd && rd == exmem.rd));

    assign rw_stall = hit_ex || hit_mem;          // writeback is covered by write-through
    assign jb_stall = is_jb || idex.ctrl.branch;

endmodule

//--- rtl/cpu_decode.sv
`timescale 1ns/1ns
`include "cpu_core_cfg.svh"
////////////////////
// decode stage
// control decode, register file and id/ex register
////////////////////
module cpu_decode import cpu_core_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  word_t  instr,
    input  logic   rw_stall,
    input  logic   freeze,
    input  memwb_t wb,
    output idex_t  idex
);

    word_t    regs [`CPU_NREG];
    opcode_t  op;
    reg_idx_t rd, rs, rt;
    reg_idx_t rb;            // second read port select
    ctrl_t    ctrl;
    word_t    rs_val;
    word_t    rb_val;

    assign op = opcode_t'(instr[31:24]);
    assign rd = instr[23:20];
    assign rs = instr[19:16];
    assign rt = instr[15:12];
    assign rb = (op == OP_ST) ? rd : rt;   // store data comes from rd

    always_comb begin
        ctrl = '0;
        case (op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
                ctrl.alu_op    = op;
                ctrl.reg_write = 1'b1;
                ctrl.flag_set  = 1'b1;
            end
            OP_ADDI: begin
                ctrl.alu_op    = op;
                ctrl.imm_sel   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.flag_set  = 1'b1;
            end
            OP_LD: begin
                ctrl.alu_op    = op;
                ctrl.imm_sel   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
            end
            OP_ST: begin
                ctrl.alu_op    = op;
                ctrl.imm_sel   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            OP_BEQ, OP_BNE, OP_BLT, OP_JMP: begin
                ctrl.alu_op = op;
                ctrl.branch = 1'b1;
            end
            default: ctrl = '0;   // nop and unknown opcodes
        endcase
    end

    //////////////////// register file

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CPU_NREG; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.we) begin
            regs[wb.rd] <= wb.result;
        end
    end

    // same cycle write-through from writeback
    assign rs_val = (wb.we && wb.rd == rs) ? wb.result : regs[rs];
    assign rb_val = (wb.we && wb.rd == rb) ? wb.result : regs[rb];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idex <= '0;
        end else if (!freeze) begin
            idex.ctrl   <= rw_stall ? ctrl_t'(0) : ctrl;   // bubble on raw stall
            idex.rs_val <= rs_val;
            idex.rt_val <= rb_val;
            idex.imm    <= {{(`CPU_XLEN-16){instr[15]}}, instr[15:0]};
            idex.rd     <= rd;
        end
    end

    // stalled word stays in decode while the bubble moves on
    a_stall_holds_instr : assert property (@(posedge clk) disable iff (!rst_n)
        rw_stall && !freeze |=> $stable(instr));

endmodule

//--- rtl/cpu_fetch.sv
`timescale 1ns/1ns
`include "cpu_core_cfg.svh"
////////////////////
// fetch stage
// load/run mode, pc, instruction memory and if/id register
////////////////////
module cpu_fetch import cpu_core_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  load_t     load,
    input  logic      start,
    input  redirect_t redirect,
    input  logic      rw_stall,
    input  logic      jb_stall,
    input  logic      freeze,
    output logic      running,
    output word_t     instr
);

    localparam int IW = $clog2(`CPU_IMEM_WORDS);

    run_mode_t mode;
    addr_t     pc;
    word_t     imem [`CPU_IMEM_WORDS];
    word_t     fetched;

    assign running = (mode == MODE_RUN);
    assign fetched = imem[pc[IW+1:2]];   // word index from byte pc

    // program words arrive from the host only in load mode
    always_ff @(posedge clk) begin
        if (mode == MODE_LOAD && load.en) begin
            imem[load.addr[IW+1:2]] <= load.data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode <= MODE_LOAD;
        end else if (mode == MODE_LOAD && start) begin
            mode <= MODE_RUN;
        end
    end

    //////////////////// pc and if/id

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc    <= '0;
            instr <= '0;
        end else if (!running) begin
            pc    <= '0;     // start always runs from 0
            instr <= '0;
        end else if (!freeze) begin
            if (redirect.valid) begin
                pc <= redirect.target;
            end else if (!rw_stall && !jb_stall) begin
                pc <= pc + addr_t'(4);
            end
            // rw stall keeps the decode word in place
            if (!rw_stall) begin
                instr <= jb_stall ? word_t'(0) : fetched;   // nop while branch in flight
            end
        end
    end

    a_no_load_in_run : assert property (@(posedge clk) disable iff (!rst_n)
        running |-> !load.en);

endmodule

//--- rtl/cpu_core_pkg.sv
////////////////////
// cpu core types
// data types, opcodes and pipeline stage records
////////////////////
`include "cpu_core_cfg.svh"

package cpu_core_pkg;

    typedef logic [`CPU_XLEN-1:0]         word_t;
    typedef logic [`CPU_AW-1:0]           addr_t;
    typedef logic [$clog2(`CPU_NREG)-1:0] reg_idx_t;

    // instruction opcodes in bits 31:24
    typedef enum logic [7:0] {
        OP_NOP  = 8'h00,
        OP_ADD  = 8'h01,
        OP_SUB  = 8'h02,
        OP_AND  = 8'h03,
        OP_OR   = 8'h04,
        OP_XOR  = 8'h05,
        OP_ADDI = 8'h10,
        OP_LD   = 8'h20,
        OP_ST   = 8'h21,
        OP_BEQ  = 8'h30,
        OP_BNE  = 8'h31,
        OP_BLT  = 8'h32,
        OP_JMP  = 8'h33
    } opcode_t;

    typedef enum logic {
        MODE_LOAD = 1'b0,
        MODE_RUN  = 1'b1
    } run_mode_t;

    typedef struct packed {
        logic  en;
        addr_t addr;   // byte address
        word_t data;
    } load_t;

    typedef struct packed {
        addr_t addr;
        word_t data;
    } host_req_t;

    typedef struct packed {
        opcode_t alu_op;
        logic    imm_sel;     // b operand from immediate
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    branch;
        logic    flag_set;
    } ctrl_t;

    //////////////////// stage registers

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    rs_val;
        word_t    rt_val;     // rd value for stores
        word_t    imm;
        reg_idx_t rd;
    } idex_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    result;
        word_t    st_data;
        reg_idx_t rd;
    } exmem_t;

    typedef struct packed {
        logic     we;
        reg_idx_t rd;
        word_t    result;
    } memwb_t;

    typedef struct packed {
        logic  valid;
        addr_t target;
    } redirect_t;

endpackage

//--- include/cpu_core_cfg.svh
////////////////////
// cpu core configuration
// widths, memory depths and the host window
////////////////////
`ifndef CPU_CORE_CFG_SVH
`define CPU_CORE_CFG_SVH

// datapath
`define CPU_XLEN 32
`define CPU_AW 16

// architectural registers
`define CPU_NREG 16

// local memories in words
`define CPU_IMEM_WORDS 256
`define CPU_DMEM_WORDS 256

// stores at or above this byte address go out to the host
`define CPU_HOST_BASE 16'h9000

`endif
